/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_dcache
FILELIST  := src.f
OBJ_DIR   := obj_dir
LOG       := sim.log

SRCS := $(filter-out +%,$(shell cat $(FILELIST))) rtl/dcache_defs.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

test: $(BIN)
	@./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "STATUS: FAIL" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* rtl/dcache_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

`include "dcache_defs.svh"

module dcache_ctrl (
    input  logic                          clk,
    input  logic                          resetn,
    input  dcache_pkg::dbus_req_t         dreq,
    output dcache_pkg::dbus_resp_t        dresp,
    output dcache_pkg::cbus_req_t         creq,
    input  dcache_pkg::cbus_resp_t        cresp,
    input  dcache_pkg::set_meta_t         set_meta,
    input  logic                          hit,
    input  dcache_pkg::way_t              hit_way,
    input  logic                          has_invalid,
    input  dcache_pkg::way_t              invalid_way,
    input  logic                          victim_dirty,
    input  logic [`DC_TAG_BITS-1:0]       victim_tag,
    input  dcache_pkg::way_t              plru_way,
    input  dcache_pkg::word_t             rd_word,
    input  dcache_pkg::line_t             cur_line,
    output logic [`DC_INDEX_BITS-1:0]     set_index,
    output logic [`DC_TAG_BITS-1:0]       req_tag,
    output dcache_pkg::way_t              victim_way,
    output logic                          meta_we,
    output dcache_pkg::set_meta_t         meta_wdata,
    output logic                          data_we,
    output logic [`DC_INDEX_BITS+1:0]     data_addr,
    output logic                          touch,
    output logic [`DC_OFFSET_BITS-3:0]    word_sel,
    output logic [3:0]                    merge_strobe,
    output dcache_pkg::word_t             merge_wdata,
    output logic                          fill_en,
    output logic [`DC_OFFSET_BITS-3:0]    fill_sel
);
    import dcache_pkg::*;

    ctrl_state_t                state;
    ctrl_state_t                state_next;
    dbus_req_t                  req;
    way_t                       vway;
    logic [`DC_OFFSET_BITS-3:0] beat;
    logic                       is_store;
    logic                       lookup_hit;
    logic                       accept;
    logic                       beat_done;

    assign set_index  = req.addr[`DC_OFFSET_BITS +: `DC_INDEX_BITS];
    assign req_tag    = req.addr[31 -: `DC_TAG_BITS];
    assign word_sel   = req.addr[`DC_OFFSET_BITS-1:2];
    assign is_store   = |req.strobe;
    assign lookup_hit = (state == LOOKUP) && hit;
    assign accept     = dreq.valid && (state == IDLE || lookup_hit);
    assign beat_done  = creq.valid && cresp.ready;

    // invalid way first, then the tree
    assign victim_way = (state == LOOKUP) ? (has_invalid ? invalid_way : plru_way) : vway;

    assign dresp.addr_ok = accept;
    assign dresp.data_ok = lookup_hit || (state == UNCACHED && cresp.ready && cresp.last);
    assign dresp.data    = (state == UNCACHED) ? cresp.data : rd_word;

    assign touch        = lookup_hit;
    assign merge_strobe = (state == LOOKUP) ? req.strobe : '0;
    assign merge_wdata  = req.data;
    assign fill_en      = (state == REFILL) && cresp.ready;
    assign fill_sel     = beat;
    assign data_addr    = {set_index, (state == LOOKUP) ? hit_way : vway};
    assign data_we      = (lookup_hit && is_store) || fill_en;

    always_comb begin
        meta_we    = 1'b0;
        meta_wdata = set_meta;
        if (lookup_hit && is_store) begin
            meta_we                     = 1'b1;
            meta_wdata[hit_way].dirty   = 1'b1;
        end else if (fill_en && cresp.last) begin
            // line complete, valid and clean
            meta_we          = 1'b1;
            meta_wdata[vway] = '{valid: 1'b1, dirty: 1'b0, tag: req_tag};
        end
    end

    always_comb begin
        creq = '0;
        case (state)
            WRITEBACK: begin
                creq.valid    = 1'b1;
                creq.is_write = 1'b1;
                creq.addr     = {victim_tag, set_index, {`DC_OFFSET_BITS{1'b0}}};
                creq.len      = `DC_LEN4;
                creq.strobe   = 4'hf;
                creq.data     = cur_line[beat];
            end
            REFILL: begin
                creq.valid    = 1'b1;
                creq.addr     = {req_tag, set_index, {`DC_OFFSET_BITS{1'b0}}};
                creq.len      = `DC_LEN4;
            end
            UNCACHED: begin
                creq.valid    = 1'b1;
                creq.is_write = is_store;
                creq.addr     = req.addr;
                creq.len      = `DC_LEN1;
                creq.strobe   = req.strobe;
                creq.data     = req.data;
            end
            default: begin
                creq = '0;
            end
        endcase
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE, LOOKUP: begin
                if (accept) begin
                    state_next = dreq.uncached ? UNCACHED : LOOKUP;
                end else if (state == IDLE || hit) begin
                    state_next = IDLE;
                end else begin
                    state_next = victim_dirty ? WRITEBACK : REFILL;
                end
            end
            WRITEBACK: begin
                if (beat_done && cresp.last) begin
                    state_next = REFILL;
                end
            end
            REFILL: begin
                // back to lookup, which then hits
                if (beat_done && cresp.last) begin
                    state_next = LOOKUP;
                end
            end
            UNCACHED: begin
                if (beat_done && cresp.last) begin
                    state_next = IDLE;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            state <= IDLE;
            beat  <= '0;
        end else begin
            state <= state_next;
            if (beat_done) begin
                beat <= cresp.last ? '0 : beat + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req <= dreq;
        end
        if (state == LOOKUP && !hit) begin
            vway <= victim_way;
        end
    end

endmodule

`default_nettype wire

/* rtl/dcache_defs.svh */
`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

// cache geometry
`define DC_WAYS         4
`define DC_SETS         16
`define DC_INDEX_BITS   4

// four 32-bit words per line
`define DC_OFFSET_BITS  4
`define DC_LINE_WORDS   4

// address bits above index and offset
`define DC_TAG_BITS     24

// burst length codes, beats minus one
`define DC_LEN1         4'd0
`define DC_LEN4         4'd3

`endif

/* rtl/dcache_line_merge.sv */
`timescale 1ns/1ns
`default_nettype none

`include "dcache_defs.svh"

module dcache_line_merge (
    input  dcache_pkg::line_t               old_line,
    input  logic [`DC_OFFSET_BITS-3:0]      word_sel,
    input  logic [3:0]                      strobe,
    input  dcache_pkg::word_t               wdata,
    input  logic                            fill_en,
    input  logic [`DC_OFFSET_BITS-3:0]      fill_sel,
    input  dcache_pkg::word_t               fill_data,
    output dcache_pkg::line_t               new_line,
    output dcache_pkg::word_t               rd_word
);

    always_comb begin
        new_line = old_line;

        // byte lanes of a store
        for (int b = 0; b < 4; b++) begin
            if (strobe[b]) begin
                new_line[word_sel][8*b +: 8] = wdata[8*b +: 8];
            end
        end

        // one refill beat
        if (fill_en) begin
            new_line[fill_sel] = fill_data;
        end
    end

    assign rd_word = old_line[word_sel];

endmodule

`default_nettype wire

/* rtl/dcache_pkg.sv */
`default_nettype none

`include "dcache_defs.svh"

package dcache_pkg;

    typedef logic [31:0] word_t;

    // processor side
    typedef struct packed {
        logic        valid;
        logic        uncached;
        logic [31:0] addr;
        logic [3:0]  strobe;
        word_t       data;
    } dbus_req_t;

    typedef struct packed {
        logic  addr_ok;
        logic  data_ok;
        word_t data;
    } dbus_resp_t;

    // memory side, burst bus
    typedef struct packed {
        logic        valid;
        logic        is_write;
        logic [31:0] addr;
        logic [3:0]  len;
        logic [3:0]  strobe;
        word_t       data;
    } cbus_req_t;

    typedef struct packed {
        logic  ready;
        logic  last;
        word_t data;
    } cbus_resp_t;

    typedef struct packed {
        logic                    valid;
        logic                    dirty;
        logic [`DC_TAG_BITS-1:0] tag;
    } way_meta_t;

    typedef way_meta_t [`DC_WAYS-1:0] set_meta_t;
    typedef word_t [`DC_LINE_WORDS-1:0] line_t;
    typedef logic [1:0] way_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITEBACK,
        REFILL,
        UNCACHED
    } ctrl_state_t;

endpackage

`default_nettype wire

/* rtl/dcache_plru.sv */
`timescale 1ns/1ns
`default_nettype none

`include "dcache_defs.svh"

module dcache_plru (
    input  logic                       clk,
    input  logic                       resetn,
    input  logic [`DC_INDEX_BITS-1:0]  index,
    output dcache_pkg::way_t           plru_way,
    input  logic                       touch,
    input  logic [`DC_INDEX_BITS-1:0]  touch_index,
    input  dcache_pkg::way_t           touch_way
);

    // [2] root, 0 picks ways 0/1 and 1 picks ways 2/3
    // [1] leaf of ways 0/1, [0] leaf of ways 2/3
    logic [2:0] tree [`DC_SETS];
    logic [2:0] cur;

    assign cur = tree[index];

    // victim follows the bits
    assign plru_way = cur[2] ? {1'b1, cur[0]} : {1'b0, cur[1]};

    always_ff @(posedge clk) begin
        if (resetn) begin
            for (int s = 0; s < `DC_SETS; s++) begin
                tree[s] <= '0;
            end
        end else if (touch) begin
            // point away from the touched way
            tree[touch_index][2] <= ~touch_way[1];
            if (touch_way[1]) begin
                tree[touch_index][0] <= ~touch_way[0];
            end else begin
                tree[touch_index][1] <= ~touch_way[0];
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/dcache_ram.sv */
`timescale 1ns/1ns
`default_nettype none

module dcache_ram #(
    parameter type entry_t = logic [31:0],
    parameter int  DEPTH   = 16
) (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] waddr,
    input  entry_t                   wdata,
    input  logic [$clog2(DEPTH)-1:0] raddr,
    output entry_t                   rdata
);

    entry_t mem [DEPTH];

    // read port is combinational
    assign rdata = mem[raddr];

    always_ff @(posedge clk) begin
        if (resetn) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            mem[waddr] <= wdata;
        end
    end

endmodule

`default_nettype wire

/* rtl/dcache_tag_match.sv */
`timescale 1ns/1ns
`default_nettype none

`include "dcache_defs.svh"

module dcache_tag_match (
    input  dcache_pkg::set_meta_t    set_meta,
    input  logic [`DC_TAG_BITS-1:0]  tag,
    output logic                     hit,
    output dcache_pkg::way_t         hit_way,
    output logic                     has_invalid,
    output dcache_pkg::way_t         invalid_way,
    input  dcache_pkg::way_t         victim_in,
    output logic                     victim_dirty,
    output logic [`DC_TAG_BITS-1:0]  victim_tag
);
    import dcache_pkg::*;

    // scan downwards so the lowest way wins
    always_comb begin
        hit         = 1'b0;
        hit_way     = '0;
        has_invalid = 1'b0;
        invalid_way = '0;
        for (int w = `DC_WAYS - 1; w >= 0; w--) begin
            if (set_meta[w].valid && set_meta[w].tag == tag) begin
                hit     = 1'b1;
                hit_way = way_t'(w);
            end
            if (!set_meta[w].valid) begin
                has_invalid = 1'b1;
                invalid_way = way_t'(w);
            end
        end
    end

    assign victim_dirty = set_meta[victim_in].valid && set_meta[victim_in].dirty;
    assign victim_tag   = set_meta[victim_in].tag;

endmodule

`default_nettype wire

/* rtl/dcache_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "dcache_defs.svh"

module dcache_top (
    input  logic                    clk,
    input  logic                    resetn,
    input  dcache_pkg::dbus_req_t   dreq,
    output dcache_pkg::dbus_resp_t  dresp,
    output dcache_pkg::cbus_req_t   creq,
    input  dcache_pkg::cbus_resp_t  cresp
);
    import dcache_pkg::*;

    set_meta_t                  set_meta;
    set_meta_t                  meta_wdata;
    line_t                      cur_line;
    line_t                      new_line;
    way_t                       hit_way;
    way_t                       invalid_way;
    way_t                       plru_way;
    way_t                       victim_way;
    word_t                      rd_word;
    word_t                      merge_wdata;
    logic                       hit;
    logic                       has_invalid;
    logic                       victim_dirty;
    logic                       meta_we;
    logic                       data_we;
    logic                       touch;
    logic                       fill_en;
    logic [`DC_TAG_BITS-1:0]    req_tag;
    logic [`DC_TAG_BITS-1:0]    victim_tag;
    logic [`DC_INDEX_BITS-1:0]  set_index;
    logic [`DC_INDEX_BITS+1:0]  data_addr;
    logic [`DC_OFFSET_BITS-3:0] word_sel;
    logic [`DC_OFFSET_BITS-3:0] fill_sel;
    logic [3:0]                 merge_strobe;

    dcache_ctrl u_ctrl (
        .clk, .resetn, .dreq, .dresp, .creq, .cresp,
        .set_meta, .hit, .hit_way, .has_invalid, .invalid_way,
        .victim_dirty, .victim_tag, .plru_way, .rd_word, .cur_line,
        .set_index, .req_tag, .victim_way, .meta_we, .meta_wdata,
        .data_we, .data_addr, .touch, .word_sel, .merge_strobe,
        .merge_wdata, .fill_en, .fill_sel
    );

    // metadata, one entry per set
    dcache_ram #(.entry_t(set_meta_t), .DEPTH(`DC_SETS)) u_meta (
        .clk, .resetn, .we(meta_we), .waddr(set_index), .wdata(meta_wdata),
        .raddr(set_index), .rdata(set_meta)
    );

    // line data, indexed by set and way
    dcache_ram #(.entry_t(line_t), .DEPTH(`DC_SETS * `DC_WAYS)) u_data (
        .clk, .resetn, .we(data_we), .waddr(data_addr), .wdata(new_line),
        .raddr(data_addr), .rdata(cur_line)
    );

    dcache_tag_match u_match (
        .set_meta, .tag(req_tag), .hit, .hit_way, .has_invalid, .invalid_way,
        .victim_in(victim_way), .victim_dirty, .victim_tag
    );

    dcache_plru u_plru (
        .clk, .resetn, .index(set_index), .plru_way, .touch,
        .touch_index(set_index), .touch_way(hit_way)
    );

    dcache_line_merge u_merge (
        .old_line(cur_line), .word_sel, .strobe(merge_strobe), .wdata(merge_wdata),
        .fill_en, .fill_sel, .fill_data(cresp.data), .new_line, .rd_word
    );

endmodule

`default_nettype wire

/* sim/dcache_chk.sv */
`timescale 1ns/1ns
`default_nettype none

`include "dcache_defs.svh"

module dcache_chk (
    input logic                    clk,
    input logic                    resetn,
    input dcache_pkg::dbus_req_t   dreq,
    input dcache_pkg::dbus_resp_t  dresp,
    input dcache_pkg::cbus_req_t   creq,
    input dcache_pkg::cbus_resp_t  cresp
);
    import dcache_pkg::*;

    int   outstanding;
    logic req_uncached;

    // accepted but not yet answered
    always @(posedge clk) begin
        if (resetn) begin
            outstanding  <= 0;
            req_uncached <= 1'b0;
        end else begin
            outstanding <= outstanding + int'(dresp.addr_ok) - int'(dresp.data_ok);
            if (dresp.addr_ok) begin
                req_uncached <= dreq.uncached;
            end
        end
    end

    stall_hold: assert property (@(posedge clk) disable iff (resetn)
        creq.valid && !cresp.ready |=> $stable(creq))
        else $error("memory request changed while ready was low");

    burst_shape: assert property (@(posedge clk) disable iff (resetn)
        creq.valid && !req_uncached |->
            creq.len == `DC_LEN4 && creq.addr[`DC_OFFSET_BITS-1:0] == '0)
        else $error("cached burst with wrong length or unaligned address");

    no_orphan_response: assert property (@(posedge clk) disable iff (resetn)
        dresp.data_ok |-> outstanding > 0)
        else $error("data_ok without an outstanding request");

    quiet_in_reset: assert property (@(posedge clk)
        resetn && $past(resetn) |-> !dresp.addr_ok && !creq.valid)
        else $error("addr_ok or memory valid high during reset");

endmodule

`default_nettype wire

/* sim/tb_dcache.sv */
`timescale 1ns/1ns
`default_nettype none

`include "dcache_defs.svh"

module tb_dcache;
    import dcache_pkg::*;

    localparam int RESET_CYCLES = 16;
    localparam int CLK_PERIOD   = 100;
    // 27 requests per pass, two passes
    localparam int NUM_REQS     = 54;

    typedef struct packed {
        logic [31:0] addr;
        logic        is_read;
        logic        want_hit;
        word_t       exp_data;
        logic [31:0] accepted;
    } pending_t;

    logic        clk = 1'b0;
    logic        resetn;
    dbus_req_t   dreq;
    dbus_resp_t  dresp;
    cbus_req_t   creq;
    cbus_resp_t  cresp = '0;
    logic [3:0]  mem_beat = '0;
    logic        random_ready = 1'b0;
    logic [31:0] cycle = '0;
    int          drive_errors = 0;
    int          resp_errors = 0;
    int          checks = 0;
    int          tests_run = 0;
    int          issued = 0;
    int          resp_idx = 0;
    word_t       memory [logic [31:0]];
    word_t       shadow [logic [31:0]];
    pending_t    pending [$];

    dcache_top u_dut (.clk, .resetn, .dreq, .dresp, .creq, .cresp);

    bind dcache_top dcache_chk u_chk (
        .clk(clk), .resetn(resetn), .dreq(dreq), .dresp(dresp), .creq(creq), .cresp(cresp)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 32'd1;
    end

    function automatic word_t init_word(input logic [31:0] addr);
        return addr ^ 32'h5a5a0000;
    endfunction

    function automatic word_t merge_bytes(input word_t old, input logic [3:0] strobe,
                                          input word_t data);
        word_t w;
        w = old;
        for (int b = 0; b < 4; b++) begin
            if (strobe[b]) begin
                w[8*b +: 8] = data[8*b +: 8];
            end
        end
        return w;
    endfunction

    function automatic word_t memory_word(input logic [31:0] addr);
        return memory.exists(addr) ? memory[addr] : init_word(addr);
    endfunction

    function automatic word_t shadow_word(input logic [31:0] addr);
        return shadow.exists(addr) ? shadow[addr] : init_word(addr);
    endfunction

    function automatic int total_errors();
        return drive_errors + resp_errors;
    endfunction

    // one transaction at a time, idle cycle after last
    always @(posedge clk) begin : memory_model
        logic [3:0]  next_beat;
        logic [31:0] a;
        next_beat = mem_beat;
        a = {creq.addr[31:2] + 30'(mem_beat), 2'b00};
        if (!resetn && creq.valid && cresp.ready) begin
            if (creq.is_write) begin
                memory[a] = merge_bytes(memory_word(a), creq.strobe, creq.data);
            end
            next_beat = cresp.last ? 4'd0 : mem_beat + 4'd1;
        end
        mem_beat <= next_beat;
        if (resetn || !creq.valid || (cresp.ready && cresp.last)) begin
            cresp <= '0;
        end else if (!random_ready || $urandom % 4 != 0) begin
            cresp.ready <= 1'b1;
            cresp.last  <= next_beat == creq.len;
            cresp.data  <= memory_word({creq.addr[31:2] + 30'(next_beat), 2'b00});
        end else begin
            cresp <= '0;
        end
    end

    always @(posedge clk) begin : response_check
        pending_t p;
        if (!resetn && issued == 0) begin
            assert (!dresp.data_ok && !creq.valid) else begin
                $display("bus activity at %0t ns before any request", $time);
                resp_errors++;
            end
        end
        if (!resetn && dresp.data_ok && resp_idx < pending.size()) begin
            p = pending[resp_idx];
            resp_idx++;
            checks++;
            if (p.is_read) begin
                assert (dresp.data == p.exp_data) else begin
                    $display("Mismatch at %0t ns: dresp.data addr %h expected %h got %h",
                             $time, p.addr, p.exp_data, dresp.data);
                    resp_errors++;
                end
            end
            if (p.want_hit) begin
                assert (cycle == p.accepted + 32'd1) else begin
                    $display("data_ok for %h came %0d cycles after addr_ok instead of 1",
                             p.addr, cycle - p.accepted);
                    resp_errors++;
                end
            end
        end
    end

    task automatic issue(input logic uncached, input logic [31:0] addr,
                         input logic [3:0] strobe, input word_t data, input logic want_hit);
        dbus_req_t r;
        pending_t  p;
        int        waited;
        r = '{valid: 1'b1, uncached: uncached, addr: addr, strobe: strobe, data: data};
        waited = 0;
        dreq <= r;
        issued++;
        do begin
            @(posedge clk);
            waited++;
        end while (!dresp.addr_ok);
        p.addr     = addr;
        p.is_read  = strobe == 4'h0;
        p.want_hit = want_hit;
        p.accepted = cycle;
        p.exp_data = '0;
        if (strobe == 4'h0) begin
            p.exp_data = shadow_word(addr);
        end else begin
            shadow[addr] = merge_bytes(shadow_word(addr), strobe, data);
        end
        pending.push_back(p);
        if (want_hit) begin
            assert (waited == 1) else begin
                $display("hit request to %h waited %0d cycles for addr_ok", addr, waited);
                drive_errors++;
            end
        end
    endtask

    task automatic drain();
        dreq <= '0;
        while (resp_idx != pending.size()) begin
            @(posedge clk);
        end
    endtask

    task automatic finish_test(input string mode, input string name, input int errors_before);
        drain();
        tests_run++;
        $display("test %0d (%s) %s: %s", tests_run, mode, name,
                 total_errors() == errors_before ? "ok" : "FAILED");
    endtask

    task automatic run_tests(input logic [31:0] base, input string mode);
        int          e;
        logic [31:0] a;
        e = total_errors();
        for (int w = 0; w < 4; w++) begin
            issue(1'b0, base + 32'h10 + 32'(w * 4), 4'h0, '0, 1'b0);
        end
        finish_test(mode, "cold line reads", e);

        e = total_errors();
        a = base + 32'h24;
        issue(1'b0, a, 4'b0110, 32'hdeadbeef, 1'b0);
        issue(1'b0, a, 4'h0, '0, 1'b0);
        issue(1'b0, a, 4'b1001, $urandom, 1'b0);
        issue(1'b0, a, 4'h0, '0, 1'b0);
        finish_test(mode, "partial store merge", e);

        // same line as the cold reads, so every access hits
        e = total_errors();
        for (int w = 0; w < 4; w++) begin
            issue(1'b0, base + 32'h10 + 32'(w * 4), 4'h0, '0, 1'b1);
        end
        finish_test(mode, "back-to-back hits", e);

        // five tags in set 3, one more than the ways
        e = total_errors();
        for (int k = 0; k < 5; k++) begin
            issue(1'b0, base + 32'h1000 * 32'(k) + 32'h34, 4'hf, $urandom, 1'b0);
        end
        for (int k = 0; k < 5; k++) begin
            issue(1'b0, base + 32'h1000 * 32'(k) + 32'h34, 4'h0, '0, 1'b0);
        end
        finish_test(mode, "dirty eviction", e);

        e = total_errors();
        a = base + 32'h64;
        issue(1'b1, a, 4'b0011, $urandom, 1'b0);
        issue(1'b1, a, 4'h0, '0, 1'b0);
        issue(1'b1, a + 32'd4, 4'hf, $urandom, 1'b0);
        issue(1'b0, a, 4'h0, '0, 1'b0);
        issue(1'b0, a + 32'd4, 4'h0, '0, 1'b0);
        finish_test(mode, "uncached access", e);
    endtask

    initial begin
        void'($urandom(32'hfa0));
        resetn = 1'b1;
        dreq   = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        resetn <= 1'b0;
        repeat (4) @(posedge clk);
        run_tests(32'h0001_0000, "ready always");
        random_ready <= 1'b1;
        run_tests(32'h0020_0000, "random ready");
        $display("%0d tests, %0d responses checked, %0d errors",
                 tests_run, checks, total_errors());
        if (total_errors() == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        #((NUM_REQS * 40 + RESET_CYCLES) * CLK_PERIOD);
        $display("watchdog expired at cycle %0d, the tests did not complete", cycle);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
+incdir+rtl
rtl/dcache_pkg.sv
rtl/dcache_ram.sv
rtl/dcache_tag_match.sv
rtl/dcache_plru.sv
rtl/dcache_line_merge.sv
rtl/dcache_ctrl.sv
rtl/dcache_top.sv
sim/dcache_chk.sv
sim/tb_dcache.sv
